/* src.f */
logic/acq_pkg.sv
logic/channel_lane.sv
logic/sample_sequencer.sv
logic/word_assembler.sv
logic/sample_fifo.sv
logic/adc_stream_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* Makefile */
# Verilator build and run of the ADC sample framer testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_top.sv */
module tb_top;

    localparam int ADC_CHANNELS = 8;
    localparam int FIFO_DEPTH   = 64;
    localparam int PERIOD       = 10;        // adc_clk_cnt runs 0..9
    localparam int SAMPLE_W     = $bits(acq_pkg::adc_sample_t);
    localparam int READY_LOW    = 0;
    localparam int READY_HIGH   = 1;
    localparam int READY_RAND   = 2;

    logic                             adc_data_clk = 1'b0;
    logic                             acq_on       = 1'b0;
    logic [ADC_CHANNELS*SAMPLE_W-1:0] adc_data     = '0;
    acq_pkg::phase_t                  adc_clk_cnt  = '0;
    logic                             big_endian   = 1'b0;
    logic                             m_ready      = 1'b0;
    logic                             m_valid;
    acq_pkg::stream_beat_t            m_beat;

    // set by the sequence on the edge, applied by the driver just after it
    logic        rst_req    = 1'b1;
    logic        be_cfg     = 1'b0;
    int          ready_mode = READY_HIGH;
    logic [63:0] period     = '0;
    int          test_num   = 0;
    logic        test_end   = 1'b0;
    logic        run_end    = 1'b0;
    logic        timed_out  = 1'b0;
    int          pair_cnt;
    int          err_cnt;
    int          fail_cnt;

    always #4 adc_data_clk = ~adc_data_clk;

    adc_stream_top #(
        .ADC_CHANNELS   (ADC_CHANNELS),
        .FIFO_DEPTH     (FIFO_DEPTH),
        .FIFO_PROG_FULL (FIFO_DEPTH - 8)
    ) u_dut (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .adc_data     (adc_data),
        .adc_clk_cnt  (adc_clk_cnt),
        .big_endian   (big_endian),
        .m_valid      (m_valid),
        .m_beat       (m_beat),
        .m_ready      (m_ready)
    );

    tb_checker u_chk (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .adc_clk_cnt  (adc_clk_cnt),
        .big_endian   (big_endian),
        .m_valid      (m_valid),
        .m_ready      (m_ready),
        .m_beat       (m_beat),
        .fifo_ready   (u_dut.fifo_ready),
        .prog_full    (u_dut.prog_full),
        .test_num     (test_num),
        .test_end     (test_end),
        .run_end      (run_end),
        .pair_cnt     (pair_cnt),
        .err_cnt      (err_cnt),
        .fail_cnt     (fail_cnt)
    );

    // ****************************************
    // input driver, one unit after each edge
    // ****************************************
    always @(posedge adc_data_clk) begin
        #1;
        if (rst_req) begin
            acq_on      = 1'b0;
            adc_clk_cnt = '0;
            period      = '0;
        end else if (!acq_on) begin
            acq_on = 1'b1;                   // first cycle of period 0 at phase 0
        end else if (adc_clk_cnt == PERIOD - 1) begin
            adc_clk_cnt = '0;
            period++;
        end else begin
            adc_clk_cnt++;
        end
        for (int k = 0; k < ADC_CHANNELS; k++)
            adc_data[k*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'(period * 37 + 64'(k) * 4099);
        big_endian = be_cfg;
        case (ready_mode)
            READY_LOW:  m_ready = 1'b0;
            READY_HIGH: m_ready = 1'b1;
            default:    m_ready = 1'($urandom() % 2);
        endcase
    end

    task automatic restart(input logic be);
        @(posedge adc_data_clk);
        rst_req = 1'b1;
        be_cfg  = be;
        repeat (3) @(posedge adc_data_clk);  // acq_on low for three cycles
        rst_req = 1'b0;
    endtask

    task automatic wait_pairs(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (pair_cnt < target && cycles < limit) begin
            @(posedge adc_data_clk);
            cycles++;
        end
        if (pair_cnt < target) begin
            $display("timeout in test %0d: %0d of %0d sample pairs after %0d cycles",
                     test_num + 1, pair_cnt, target, cycles);
            timed_out = 1'b1;
        end
    endtask

    task automatic close_test(input int num);
        @(posedge adc_data_clk);
        #1;
        test_num = num;
        test_end = 1'b1;
        @(posedge adc_data_clk);
        #1;
        test_end = 1'b0;
    endtask

    task automatic run_stream(input int num, input logic be, input int pairs);
        if (timed_out) return;
        ready_mode = READY_HIGH;
        restart(be);
        wait_pairs(pairs, pairs * PERIOD + 100);
        close_test(num);
    endtask

    initial begin
        void'($urandom(32'h3ee7_8074));
        run_stream(1, 1'b0, 40);
        run_stream(2, 1'b1, 40);
        run_stream(3, 1'b0, 2100);           // two packet boundaries
        if (!timed_out) begin
            ready_mode = READY_LOW;          // FIFO fills, then drops whole samples
            restart(1'b0);
            repeat (120 * PERIOD) @(posedge adc_data_clk);
            ready_mode = READY_RAND;
            wait_pairs(60, 4000);
            close_test(4);
        end
        if (!timed_out) begin
            ready_mode = READY_HIGH;
            restart(1'b0);
            wait_pairs(5, 200);
            ready_mode = READY_LOW;          // leave words queued, stop mid period
            repeat (23) @(posedge adc_data_clk);
            rst_req    = 1'b1;
            ready_mode = READY_HIGH;
            repeat (3) @(posedge adc_data_clk);
            rst_req = 1'b0;
            wait_pairs(10, 200);
            close_test(5);
        end
        @(posedge adc_data_clk);
        #1;
        run_end = 1'b1;
        @(posedge adc_data_clk);
        #1;
        run_end = 1'b0;
        if (timed_out || fail_cnt != 0 || err_cnt != 0) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

/* testbench/tb_checker.sv */
module tb_checker (
    input  logic                  adc_data_clk,
    input  logic                  acq_on,
    input  acq_pkg::phase_t       adc_clk_cnt,
    input  logic                  big_endian,
    input  logic                  m_valid,
    input  logic                  m_ready,
    input  acq_pkg::stream_beat_t m_beat,
    input  logic                  fifo_ready,     // FIFO state at the accept decision
    input  logic                  prog_full,
    input  int                    test_num,
    input  logic                  test_end,       // one cycle, closes a test
    input  logic                  run_end,        // one cycle, closes the run
    output int                    pair_cnt,
    output int                    err_cnt,
    output int                    fail_cnt
);

    localparam int PKT_LEN = 1024;           // accepted samples per packet

    bit          dropped [4096];             // period had no room at the decision edge
    logic [63:0] period    = '0;             // tracks the DUT sample counter
    logic [63:0] next_n    = '0;             // lowest counter value the next pair may carry
    logic [63:0] cur_n     = '0;
    logic        high_next = 1'b0;           // low word seen, high word due
    logic        held      = 1'b0;           // beat offered last edge and not taken
    acq_pkg::stream_beat_t held_beat = '0;
    int          pairs     = 0;
    int          errs      = 0;
    int          skipped   = 0;
    int          tests     = 0;
    int          fails     = 0;
    int          err_mark  = 0;
    int          skip_mark = 0;

    function automatic logic [127:0] reverse_bytes(input logic [127:0] w);
        logic [127:0] r;
        for (int b = 0; b < 16; b++) begin
            r[8*b +: 8] = w[8*(15-b) +: 8];
        end
        return r;
    endfunction

    // ****************************************
    // reference words of sample n
    // ****************************************
    function automatic logic [255:0] expected_pair(input logic [63:0] n, input logic be);
        logic [255:0] w;                     // low word in 127:0, high word above
        logic [17:0]  smp;
        for (int k = 0; k < 8; k++) begin
            smp = 18'(n * 37 + 64'(k) * 4099);
            w[32*k +: 32] = {smp, 2'b00, 4'(k), n[8*k +: 8]};  // lane k carries byte k
        end
        if (be) begin
            w[127:0]   = reverse_bytes(w[127:0]);
            w[255:128] = reverse_bytes(w[255:128]);
        end
        return w;
    endfunction

    function automatic string test_name(input int num);
        case (num)
            1:       return "little-endian framing";
            2:       return "big-endian swap";
            3:       return "packet boundary";
            4:       return "back-pressure";
            default: return "reset mid-run";
        endcase
    endfunction

    always @(posedge adc_data_clk) begin : watch
        logic [255:0] exp_w;
        logic [63:0]  n;
        logic [63:0]  m;
        logic [7:0]   byte0;
        logic         exp_last;
        int           missing;
        if (!acq_on) begin
            if (m_valid) begin
                errs++;
                $display("stream still valid while acquisition is stopped");
            end
            period    = '0;                  // DUT counters restart from zero
            next_n    = '0;
            high_next = 1'b0;
            held      = 1'b0;
            pairs     = 0;
        end else begin
            // a stalled beat stays offered and unchanged
            if (held && (m_valid !== 1'b1 || m_beat !== held_beat)) begin
                errs++;
                $display("** Error: m_valid/m_beat under back-pressure got %h/%h expected %h/%h",
                         m_valid, m_beat, 1'b1, held_beat);
            end
            if (m_valid && m_ready && !high_next) begin
                byte0 = big_endian ? m_beat.data[127:120] : m_beat.data[7:0];
                n = next_n;
                while (n[7:0] != byte0 && n < period)
                    n++;                     // skip over dropped samples
                if (n[7:0] != byte0) begin
                    errs++;
                    $display("** Error: m_beat.data counter byte got %h expected %h",
                             byte0, next_n[7:0]);
                    n = next_n;
                end
                missing = 0;
                for (m = next_n; m < n; m++)
                    if (!dropped[m[11:0]]) missing++;
                if (missing != 0) begin
                    errs++;
                    $display("%0d samples before counter %0d lost while the FIFO had room",
                             missing, n);
                end
                skipped += int'(n - next_n);
                cur_n = n;
                exp_w = expected_pair(cur_n, big_endian);
                if (m_beat.data !== exp_w[127:0] || m_beat.last !== 1'b0) begin
                    errs++;
                    $display("** Error: m_beat (low word, n=%0d) got %h/%h expected %h/%h",
                             cur_n, m_beat.data, m_beat.last, exp_w[127:0], 1'b0);
                end
                high_next = 1'b1;
            end else if (m_valid && m_ready) begin
                exp_w    = expected_pair(cur_n, big_endian);
                exp_last = (pairs % PKT_LEN) == PKT_LEN - 1;   // closes every packet
                if (m_beat.data !== exp_w[255:128] || m_beat.last !== exp_last) begin
                    errs++;
                    $display("** Error: m_beat (high word, n=%0d) got %h/%h expected %h/%h",
                             cur_n, m_beat.data, m_beat.last, exp_w[255:128], exp_last);
                end
                pairs++;
                next_n    = cur_n + 1;
                high_next = 1'b0;
            end
            held      = m_valid && !m_ready;
            held_beat = m_beat;
            if (adc_clk_cnt == acq_pkg::PHASE_HIGH_WORD)
                dropped[period[11:0]] = !fifo_ready || prog_full;  // decision edge
            if (adc_clk_cnt == acq_pkg::PHASE_ADVANCE)
                period++;
        end
        if (test_end) begin
            tests++;
            if (errs != err_mark) fails++;
            $display("test %0d %s: %0d pairs, %0d skipped, %0d errors, %s", test_num,
                     test_name(test_num), pairs, skipped - skip_mark, errs - err_mark,
                     (errs != err_mark) ? "FAILED" : "ok");
            err_mark  = errs;
            skip_mark = skipped;
        end
        if (run_end)
            $display("%0d tests, %0d failed, %0d errors", tests, fails, errs);
        pair_cnt <= pairs;                   // settled values for the sequence
        err_cnt  <= errs;
        fail_cnt <= fails;
    end

endmodule

/* logic/adc_stream_top.sv */
module adc_stream_top #(
    parameter int ADC_CHANNELS   = 8,       // even, at most 16
    parameter int FIFO_DEPTH     = 64,
    parameter int FIFO_PROG_FULL = FIFO_DEPTH - 8
) (
    input  logic                                               adc_data_clk,
    input  logic                                               acq_on,
    input  logic [ADC_CHANNELS*$bits(acq_pkg::adc_sample_t)-1:0] adc_data,
    input  acq_pkg::phase_t                                    adc_clk_cnt,
    input  logic                                               big_endian,
    output logic                                               m_valid,
    output acq_pkg::stream_beat_t                              m_beat,
    input  logic                                               m_ready
);

    localparam int SAMPLE_W    = $bits(acq_pkg::adc_sample_t);
    localparam int BYTE_W      = $bits(acq_pkg::count_byte_t);
    localparam int COUNT_BYTES = $bits(acq_pkg::sample_count_t) / BYTE_W;  // 8

    acq_pkg::lane_word_t [ADC_CHANNELS-1:0] lane_words;
    acq_pkg::sample_count_t                 count_bytes;
    acq_pkg::stream_word_t                  asm_word;
    acq_pkg::stream_beat_t                  wr_beat;
    logic                                   wr_valid;
    logic                                   wr_last;
    logic                                   fifo_ready;
    logic                                   prog_full;

    sample_sequencer u_seq (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .adc_clk_cnt  (adc_clk_cnt),
        .fifo_ready   (fifo_ready),
        .prog_full    (prog_full),
        .count_bytes  (count_bytes),
        .wr_valid     (wr_valid),
        .wr_last      (wr_last)
    );

    // ****************************************
    // one lane per channel
    // ****************************************
    for (genvar k = 0; k < ADC_CHANNELS; k++) begin : g_lane
        channel_lane #(
            .LANE_INDEX (k)
        ) u_lane (
            .adc_data_clk (adc_data_clk),
            .acq_on       (acq_on),
            .adc_clk_cnt  (adc_clk_cnt),
            .sample       (adc_data[k*SAMPLE_W +: SAMPLE_W]),
            .count_byte   (count_bytes[(k % COUNT_BYTES)*BYTE_W +: BYTE_W]),  // byte k
            .lane_word    (lane_words[k])
        );
    end

    word_assembler #(
        .ADC_CHANNELS (ADC_CHANNELS)
    ) u_asm (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .adc_clk_cnt  (adc_clk_cnt),
        .big_endian   (big_endian),
        .lane_words   (lane_words),
        .asm_word     (asm_word)
    );

    assign wr_beat.data = asm_word;
    assign wr_beat.last = wr_last;          // lines up with the high word

    sample_fifo #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .FIFO_PROG_FULL (FIFO_PROG_FULL)
    ) u_fifo (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .wr_valid     (wr_valid),
        .wr_beat      (wr_beat),
        .fifo_ready   (fifo_ready),
        .prog_full    (prog_full),
        .m_valid      (m_valid),
        .m_beat       (m_beat),
        .m_ready      (m_ready)
    );

endmodule

/* logic/sample_fifo.sv */
module sample_fifo #(
    parameter int FIFO_DEPTH     = 64,                // power of two
    parameter int FIFO_PROG_FULL = FIFO_DEPTH - 8
) (
    input  logic                  adc_data_clk,
    input  logic                  acq_on,
    input  logic                  wr_valid,
    input  acq_pkg::stream_beat_t wr_beat,
    output logic                  fifo_ready,
    output logic                  prog_full,
    output logic                  m_valid,
    output acq_pkg::stream_beat_t m_beat,
    input  logic                  m_ready
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = AW + 1;                       // occupancy reaches FIFO_DEPTH
    localparam logic [CW-1:0] FULL_LVL  = CW'(FIFO_DEPTH);
    localparam logic [CW-1:0] PFULL_LVL = CW'(FIFO_PROG_FULL);

    acq_pkg::stream_beat_t mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;                   // words in the array, not the output stage
    logic          push;
    logic          pop;

    assign fifo_ready = (count != FULL_LVL);
    assign prog_full  = (count >= PFULL_LVL);
    assign push       = wr_valid && fifo_ready;
    assign pop        = (count != '0) && (!m_valid || m_ready);   // output stage free

    // ****************************************
    // pointers, occupancy, output valid
    // ****************************************
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            m_valid <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;    // wraps at the power of two
            if (pop) begin
                rd_ptr  <= rd_ptr + 1'b1;
                m_valid <= 1'b1;
            end else if (m_ready) begin
                m_valid <= 1'b0;            // beat taken, nothing behind it
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and output beat
    always_ff @(posedge adc_data_clk) begin
        if (push)
            mem[wr_ptr] <= wr_beat;
        if (pop)
            m_beat <= mem[rd_ptr];          // held while m_valid waits on m_ready
    end

    // the threshold margin must keep the second word of a sample in
    a_no_overflow: assert property (@(posedge adc_data_clk) disable iff (!acq_on)
        wr_valid |-> fifo_ready)
        else $error("write strobe while FIFO full");

endmodule

/* logic/word_assembler.sv */
module word_assembler #(
    parameter int ADC_CHANNELS = 8
) (
    input  logic                                     adc_data_clk,
    input  logic                                     acq_on,
    input  acq_pkg::phase_t                          adc_clk_cnt,
    input  logic                                     big_endian,
    input  acq_pkg::lane_word_t [ADC_CHANNELS-1:0]   lane_words,
    output acq_pkg::stream_word_t                    asm_word
);

    localparam int LPW        = acq_pkg::LANES_PER_WORD;
    localparam int WORD_BYTES = $bits(acq_pkg::stream_word_t) / 8;   // 16

    acq_pkg::stream_word_t group;           // four lanes, lane 0 in the low bits
    acq_pkg::stream_word_t swapped;

    // full 16 byte reversal of one beat
    function automatic acq_pkg::stream_word_t byte_swap(input acq_pkg::stream_word_t w);
        acq_pkg::stream_word_t r;
        for (int b = 0; b < WORD_BYTES; b++) begin
            r[8*b +: 8] = w[8*(WORD_BYTES-1-b) +: 8];
        end
        return r;
    endfunction

    // low lanes were captured one edge ago when the high phase arrives
    assign group = (adc_clk_cnt == acq_pkg::PHASE_HIGH_WORD) ? lane_words[LPW-1:0]
                                                              : lane_words[2*LPW-1:LPW];

    assign swapped = big_endian ? byte_swap(group) : group;

    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            asm_word <= '0;
        end else begin
            asm_word <= swapped;            // low word at high phase, high word after
        end
    end

endmodule

/* logic/sample_sequencer.sv */
module sample_sequencer (
    input  logic                   adc_data_clk,
    input  logic                   acq_on,
    input  acq_pkg::phase_t        adc_clk_cnt,
    input  logic                   fifo_ready,
    input  logic                   prog_full,
    output acq_pkg::sample_count_t count_bytes,    // lane k takes byte k
    output logic                   wr_valid,
    output logic                   wr_last
);

    // window of one conversion period, opened by the low word phase
    typedef enum logic [1:0] {
        ST_IDLE,                            // waiting for the low word phase
        ST_LOW,                             // low lanes captured
        ST_HIGH,                            // high lanes captured, decision taken
        ST_PACKET                           // low word written, high word next
    } window_t;

    window_t state;
    logic [acq_pkg::PKT_SAMPLES_LOG2-1:0] pkt_cnt;  // accepted samples in this packet
    logic accept;

    // room for a whole sample, both words or none
    assign accept = fifo_ready && !prog_full;

    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            state       <= ST_IDLE;
            count_bytes <= '0;
            pkt_cnt     <= '0;
            wr_valid    <= 1'b0;
            wr_last     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (adc_clk_cnt == acq_pkg::PHASE_LOW_WORD)
                        state <= ST_LOW;
                end
                ST_LOW: begin
                    if (adc_clk_cnt == acq_pkg::PHASE_HIGH_WORD) begin
                        state    <= ST_HIGH;
                        wr_valid <= accept;          // strobe opens for two words
                    end else begin
                        state <= ST_IDLE;            // phase count jumped, skip period
                    end
                end
                ST_HIGH: begin
                    state <= ST_PACKET;
                    if (wr_valid && adc_clk_cnt == acq_pkg::PHASE_PACKET) begin
                        pkt_cnt <= pkt_cnt + 1'b1;
                        wr_last <= &pkt_cnt;         // 1024th sample closes the packet
                    end
                end
                ST_PACKET: begin
                    state    <= ST_IDLE;
                    wr_valid <= 1'b0;                // high word taken this edge
                    wr_last  <= 1'b0;
                    if (adc_clk_cnt == acq_pkg::PHASE_ADVANCE)
                        count_bytes <= count_bytes + 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ****************************************
    // strobe shape
    // ****************************************
    // exactly two beats per accepted sample, never split
    a_strobe_len: assert property (@(posedge adc_data_clk) disable iff (!acq_on)
        $rose(wr_valid) |=> wr_valid ##1 !wr_valid)
        else $error("wr_valid not two cycles long");

    // last only rides on the second word of a sample
    a_last_high: assert property (@(posedge adc_data_clk) disable iff (!acq_on)
        $rose(wr_last) |-> wr_valid && $past(wr_valid))
        else $error("wr_last outside the high word");

endmodule

/* logic/channel_lane.sv */
module channel_lane #(
    parameter int LANE_INDEX = 0            // channel number, also the tag
) (
    input  logic                 adc_data_clk,
    input  logic                 acq_on,
    input  acq_pkg::phase_t      adc_clk_cnt,
    input  acq_pkg::adc_sample_t sample,
    input  acq_pkg::count_byte_t count_byte,
    output acq_pkg::lane_word_t  lane_word
);

    // low group captures one phase ahead of the high group
    localparam acq_pkg::phase_t CAPTURE_PHASE =
        (LANE_INDEX < acq_pkg::LANES_PER_WORD) ? acq_pkg::PHASE_LOW_WORD
                                               : acq_pkg::PHASE_HIGH_WORD;
    localparam bit IN_STREAM = (LANE_INDEX < 2 * acq_pkg::LANES_PER_WORD); // only 8 lanes fit
    localparam acq_pkg::chan_tag_t TAG = acq_pkg::chan_tag_t'(LANE_INDEX);

    logic capture;                          // this lane's phase has come round

    assign capture = IN_STREAM && (adc_clk_cnt == CAPTURE_PHASE);

    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            lane_word <= '0;
        end else if (capture) begin
            // msb first: sample, zero pad, tag, counter byte
            lane_word <= {sample, {acq_pkg::LANE_PAD_W{1'b0}}, TAG, count_byte};
        end
    end

    // the word moves only on the edge of its own capture phase
    a_capture_edge: assert property (@(posedge adc_data_clk) disable iff (!acq_on)
        $changed(lane_word) |-> ($past(adc_clk_cnt) == CAPTURE_PHASE))
        else $error("lane %0d changed outside its capture phase", LANE_INDEX);

endmodule

/* logic/acq_pkg.sv */
package acq_pkg;

    // ****************************************
    // widths that carry a meaning
    // ****************************************
    typedef logic [17:0]  adc_sample_t;     // one converter sample
    typedef logic [5:0]   phase_t;          // position inside one conversion period
    typedef logic [3:0]   chan_tag_t;       // channel number carried in each lane
    typedef logic [31:0]  lane_word_t;      // sample, pad, tag, counter byte
    typedef logic [127:0] stream_word_t;    // four lanes, one DMA beat
    typedef logic [63:0]  sample_count_t;   // free-running sample counter
    typedef logic [7:0]   count_byte_t;     // one byte of the sample counter

    // one beat as it sits in the FIFO and leaves on the stream
    typedef struct packed {
        stream_word_t data;
        logic         last;                 // closes a packet, only on a high word
    } stream_beat_t;

    // ****************************************
    // phases inside one conversion period
    // ****************************************
    localparam phase_t PHASE_LOW_WORD  = 6'd1;  // lanes 0..3 capture
    localparam phase_t PHASE_HIGH_WORD = 6'd2;  // lanes 4..7 capture, accept decision
    localparam phase_t PHASE_PACKET    = 6'd3;  // packet count and last flag
    localparam phase_t PHASE_ADVANCE   = 6'd4;  // counter steps, strobe drops

    // lane layout
    localparam int LANES_PER_WORD   = 4;
    localparam int PKT_SAMPLES_LOG2 = 10;       // 1024 accepted samples per packet

    // zero bits between sample and tag, two with the widths above
    localparam int LANE_PAD_W = $bits(lane_word_t)
                              - $bits(adc_sample_t)
                              - $bits(chan_tag_t)
                              - $bits(count_byte_t);

endpackage
